// ==== hdl/fwd_pkg.sv ====
package fwd_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int neuron_num   = 4;
    localparam int layer_max    = 2;
    localparam int act_width    = 9;
    localparam int weight_width = 16;
    localparam int out_width    = 12;
    localparam int fraction     = 8;
    localparam int acc_width    = 27;
    localparam int idx_width    = 2;
    localparam int layer_width  = 2;
    localparam int waddr_width  = 5;

    // saturation and clamp limits
    localparam int out_max   = (1 << (out_width - 1)) - 1;
    localparam int out_min   = -(1 << (out_width - 1));
    localparam int act_clamp = 255;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic signed [act_width-1:0]                act_t;
    typedef logic [neuron_num*act_width-1:0]            act_vec_t;
    typedef logic signed [weight_width-1:0]             weight_t;
    typedef logic [neuron_num*weight_width-1:0]         weight_row_t;
    typedef logic signed [out_width-1:0]                out_t;
    typedef logic [neuron_num*out_width-1:0]            out_vec_t;
    typedef logic signed [acc_width-1:0]                acc_t;
    typedef logic [idx_width-1:0]                       idx_t;
    typedef logic [layer_width-1:0]                     layer_t;
    typedef logic [waddr_width-1:0]                     waddr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_acc,
        st_store,
        st_finish
    } ctrl_state_t;

endpackage

// ==== hdl/fwd_ctrl_if.sv ====
interface fwd_ctrl_if;

    // position in the forward pass
    fwd_pkg::layer_t layer_idx;
    fwd_pkg::idx_t   in_idx;
    logic            last_idx;
    logic            last_layer;

    // sequencing strobes
    logic            cnt_clear;
    logic            idx_step;
    logic            layer_step;
    logic            acc_clear;
    logic            acc_en;
    logic            act_store;

    modport fsm (
        input  last_idx, last_layer,
        output cnt_clear, idx_step, layer_step, acc_clear, acc_en, act_store
    );

    modport counter (
        input  cnt_clear, idx_step, layer_step,
        output layer_idx, in_idx, last_idx, last_layer
    );

    modport datapath (
        input  layer_idx, in_idx, cnt_clear, acc_clear, acc_en, act_store
    );

endinterface

// ==== hdl/layer_ctrl.sv ====
module layer_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    output logic       busy,
    output logic       done,
    fwd_ctrl_if.fsm    ctrl
);

    fwd_pkg::ctrl_state_t state_q;
    fwd_pkg::ctrl_state_t state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= fwd_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // one clear, neuron_num accumulate cycles and one store per layer
    always_comb begin
        state_d = state_q;
        case (state_q)
            fwd_pkg::st_idle: begin
                if (start) begin
                    state_d = fwd_pkg::st_clear;
                end
            end
            fwd_pkg::st_clear:  state_d = fwd_pkg::st_acc;
            fwd_pkg::st_acc: begin
                if (ctrl.last_idx) begin
                    state_d = fwd_pkg::st_store;
                end
            end
            fwd_pkg::st_store: begin
                state_d = ctrl.last_layer ? fwd_pkg::st_finish : fwd_pkg::st_clear;
            end
            fwd_pkg::st_finish: state_d = fwd_pkg::st_idle;
            default:            state_d = fwd_pkg::st_idle;
        endcase
    end

    // strobes decoded from the state register
    assign ctrl.cnt_clear  = (state_q == fwd_pkg::st_idle) && start;
    assign ctrl.acc_clear  = (state_q == fwd_pkg::st_clear);
    assign ctrl.acc_en     = (state_q == fwd_pkg::st_acc);
    assign ctrl.idx_step   = (state_q == fwd_pkg::st_acc);
    assign ctrl.act_store  = (state_q == fwd_pkg::st_store);
    assign ctrl.layer_step = (state_q == fwd_pkg::st_store);

    assign busy = (state_q == fwd_pkg::st_clear) || (state_q == fwd_pkg::st_acc) ||
                  (state_q == fwd_pkg::st_store);
    assign done = (state_q == fwd_pkg::st_finish);

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // done only ever follows the final store of a busy run
    a_done_after_busy: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> !busy && $past(busy)
    );

    a_acc_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(ctrl.acc_en && ctrl.acc_clear)
    );

endmodule

// ==== hdl/mac_counter.sv ====
module mac_counter (
    input  logic        clk,
    input  logic        rst_n,
    fwd_ctrl_if.counter cnt
);

    fwd_pkg::idx_t   in_idx_q;
    fwd_pkg::layer_t layer_idx_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_idx_q    <= '0;
            layer_idx_q <= '0;
        end else if (cnt.cnt_clear) begin
            in_idx_q    <= '0;
            layer_idx_q <= '0;
        end else begin
            // wraps back to input 0 after the last input
            if (cnt.idx_step) begin
                in_idx_q <= cnt.last_idx ? '0 : in_idx_q + 1'b1;
            end
            // holds on the last layer
            if (cnt.layer_step && !cnt.last_layer) begin
                layer_idx_q <= layer_idx_q + 1'b1;
            end
        end
    end

    assign cnt.in_idx     = in_idx_q;
    assign cnt.layer_idx  = layer_idx_q;
    assign cnt.last_idx   = (in_idx_q == fwd_pkg::idx_t'(fwd_pkg::neuron_num - 1));
    assign cnt.last_layer = (layer_idx_q == fwd_pkg::layer_t'(fwd_pkg::layer_max - 1));

    a_layer_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        layer_idx_q <= fwd_pkg::layer_t'(fwd_pkg::layer_max - 1)
    );

endmodule

// ==== hdl/weight_mem.sv ====
module weight_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 w_we,
    input  fwd_pkg::waddr_t      w_addr,
    input  fwd_pkg::weight_t     w_data,
    fwd_ctrl_if.datapath         dp,
    output fwd_pkg::weight_row_t row
);

    localparam int depth = 1 << fwd_pkg::waddr_width;

    fwd_pkg::weight_t mem_q [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem_q[i] <= '0;
            end
        end else if (w_we) begin
            mem_q[w_addr] <= w_data;
        end
    end

    // address is layer * 16 + neuron * 4 + input index
    always_comb begin
        fwd_pkg::waddr_t addr;
        row = '0;
        for (int n = 0; n < fwd_pkg::neuron_num; n++) begin
            addr = fwd_pkg::waddr_t'(dp.layer_idx) *
                       fwd_pkg::waddr_t'(fwd_pkg::neuron_num * fwd_pkg::neuron_num) +
                   fwd_pkg::waddr_t'(n * fwd_pkg::neuron_num) +
                   fwd_pkg::waddr_t'(dp.in_idx);
            row[n*fwd_pkg::weight_width +: fwd_pkg::weight_width] = mem_q[addr];
        end
    end

endmodule

// ==== hdl/neuron_array.sv ====
module neuron_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    fwd_ctrl_if.datapath         dp,
    input  fwd_pkg::weight_row_t row,
    input  fwd_pkg::act_t        cur_act,
    output fwd_pkg::out_vec_t    result,
    output fwd_pkg::act_vec_t    next_act,
    output logic                 overflow
);

    localparam int nn = fwd_pkg::neuron_num;
    localparam int ow = fwd_pkg::out_width;
    localparam int aw = fwd_pkg::act_width;

    fwd_pkg::acc_t        acc_q [nn];
    fwd_pkg::acc_t        prod  [nn];
    fwd_pkg::out_vec_t    sat_vec;
    logic [nn-1:0]        sat_hit;

    ////////////////////////////////////////////////////////////
    // per-neuron arithmetic
    ////////////////////////////////////////////////////////////

    always_comb begin
        fwd_pkg::weight_t w;
        fwd_pkg::acc_t    shifted;
        fwd_pkg::out_t    sat;
        sat_vec  = '0;
        next_act = '0;
        sat_hit  = '0;
        for (int n = 0; n < nn; n++) begin
            w       = fwd_pkg::weight_t'(row[n*fwd_pkg::weight_width +: fwd_pkg::weight_width]);
            prod[n] = fwd_pkg::acc_t'(cur_act) * fwd_pkg::acc_t'(w);

            // arithmetic shift floors toward minus infinity
            shifted = acc_q[n] >>> fwd_pkg::fraction;
            if (shifted > fwd_pkg::acc_t'(fwd_pkg::out_max)) begin
                sat        = fwd_pkg::out_t'(fwd_pkg::out_max);
                sat_hit[n] = 1'b1;
            end else if (shifted < fwd_pkg::acc_t'(fwd_pkg::out_min)) begin
                sat        = fwd_pkg::out_t'(fwd_pkg::out_min);
                sat_hit[n] = 1'b1;
            end else begin
                sat = fwd_pkg::out_t'(shifted);
            end
            sat_vec[n*ow +: ow] = sat;

            // relu, then clamp to the activation ceiling
            if (sat[ow-1]) begin
                next_act[n*aw +: aw] = '0;
            end else if (sat > fwd_pkg::out_t'(fwd_pkg::act_clamp)) begin
                next_act[n*aw +: aw] = fwd_pkg::act_t'(fwd_pkg::act_clamp);
            end else begin
                next_act[n*aw +: aw] = fwd_pkg::act_t'(sat);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // accumulators and result registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < nn; n++) begin
                acc_q[n] <= '0;
            end
        end else if (dp.acc_clear) begin
            for (int n = 0; n < nn; n++) begin
                acc_q[n] <= '0;
            end
        end else if (dp.acc_en) begin
            for (int n = 0; n < nn; n++) begin
                acc_q[n] <= acc_q[n] + prod[n];
            end
        end
    end

    // overflow is sticky over all layers of one run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result   <= '0;
            overflow <= 1'b0;
        end else if (start && dp.cnt_clear) begin
            overflow <= 1'b0;
        end else if (dp.act_store) begin
            result   <= sat_vec;
            overflow <= overflow | (|sat_hit);
        end
    end

endmodule

// ==== hdl/activation_stack.sv ====
module activation_stack (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  fwd_pkg::act_vec_t in_vec,
    input  fwd_pkg::act_vec_t next_act,
    fwd_ctrl_if.datapath      dp,
    output fwd_pkg::act_t     cur_act
);

    localparam int aw = fwd_pkg::act_width;

    // slot l holds the input vector of layer l
    fwd_pkg::act_vec_t stack_q [fwd_pkg::layer_max];
    fwd_pkg::act_vec_t sel_vec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < fwd_pkg::layer_max; l++) begin
                stack_q[l] <= '0;
            end
        end else if (start && dp.cnt_clear) begin
            // only a start accepted by the controller loads layer 0
            stack_q[0] <= in_vec;
        end else if (dp.act_store) begin
            // the last layer has no following slot
            for (int l = 1; l < fwd_pkg::layer_max; l++) begin
                if (int'(dp.layer_idx) + 1 == l) begin
                    stack_q[l] <= next_act;
                end
            end
        end
    end

    always_comb begin
        sel_vec = '0;
        for (int l = 0; l < fwd_pkg::layer_max; l++) begin
            if (dp.layer_idx == fwd_pkg::layer_t'(l)) begin
                sel_vec = stack_q[l];
            end
        end
    end

    assign cur_act = fwd_pkg::act_t'(sel_vec[dp.in_idx*aw +: aw]);

endmodule

// ==== hdl/fwd_net_top.sv ====
module fwd_net_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  fwd_pkg::act_vec_t in_vec,
    input  logic              w_we,
    input  fwd_pkg::waddr_t   w_addr,
    input  fwd_pkg::weight_t  w_data,
    output fwd_pkg::out_vec_t result,
    output logic              done,
    output logic              busy,
    output logic              overflow
);

    fwd_pkg::weight_row_t row;
    fwd_pkg::act_t        cur_act;
    fwd_pkg::act_vec_t    next_act;

    fwd_ctrl_if ctrl_bus ();

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    layer_ctrl u_layer_ctrl (
        .clk   (clk     ),
        .rst_n (rst_n   ),
        .start (start   ),
        .busy  (busy    ),
        .done  (done    ),
        .ctrl  (ctrl_bus)
    );

    mac_counter u_mac_counter (
        .clk   (clk     ),
        .rst_n (rst_n   ),
        .cnt   (ctrl_bus)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    weight_mem u_weight_mem (
        .clk    (clk     ),
        .rst_n  (rst_n   ),
        .w_we   (w_we    ),
        .w_addr (w_addr  ),
        .w_data (w_data  ),
        .dp     (ctrl_bus),
        .row    (row     )
    );

    activation_stack u_activation_stack (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .start    (start   ),
        .in_vec   (in_vec  ),
        .next_act (next_act),
        .dp       (ctrl_bus),
        .cur_act  (cur_act )
    );

    neuron_array u_neuron_array (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .start    (start   ),
        .dp       (ctrl_bus),
        .row      (row     ),
        .cur_act  (cur_act ),
        .result   (result  ),
        .next_act (next_act),
        .overflow (overflow)
    );

endmodule

// ==== bench/fwd_checker.sv ====
module fwd_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  fwd_pkg::out_vec_t result,
    input  logic              done,
    input  logic              busy,
    input  logic              overflow,
    output int                errors,
    output int                checks
);
    timeunit 1ns;
    timeprecision 1ps;

    // one clear, one accumulate per input and one store per layer, plus the finish cycle
    localparam int run_latency = 1 + (fwd_pkg::neuron_num + 2) * fwd_pkg::layer_max;

    string             name_q [$];
    fwd_pkg::out_vec_t res_q  [$];
    logic              ovf_q  [$];

    int    err_cnt = 0;
    int    chk_cnt = 0;
    int    cyc = 0;
    int    start_cyc = 0;
    logic  reset_checked = 1'b0;
    // run timing tracked from the sampled starts alone
    logic  run_open = 1'b0;
    string run_name = "";

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task automatic expect_run(input string name, input fwd_pkg::out_vec_t res, input logic ovf);
        name_q.push_back(name);
        res_q.push_back(res);
        ovf_q.push_back(ovf);
    endtask

    function automatic int pending_runs();
        return name_q.size();
    endfunction

    ////////////////////////////////////////////////////////////
    // compare on every edge against the pre-edge values
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        string             name;
        fwd_pkg::out_vec_t exp_res;
        logic              exp_ovf;
        if (rst_n && !reset_checked) begin
            reset_checked = 1'b1;
            chk_cnt++;
            if (done !== 1'b0 || busy !== 1'b0 || overflow !== 1'b0 || result !== '0) begin
                $display("FAIL reset: expected done 0 busy 0 ovf 0 result 0 actual %b %b %b %h",
                         done, busy, overflow, result);
                err_cnt++;
            end
        end
        // a start opens a run only while no run is open
        if (rst_n && start && !run_open) begin
            run_open  = 1'b1;
            start_cyc = cyc;
            if (name_q.size() != 0) begin
                run_name = name_q[0];
            end else begin
                run_name = "unexpected";
            end
        end
        // busy covers every cycle between the start and the done
        if (rst_n && run_open && cyc > start_cyc && cyc - start_cyc < run_latency) begin
            chk_cnt++;
            if (busy !== 1'b1) begin
                $display("FAIL %s busy: expected 1 actual %b", run_name, busy);
                err_cnt++;
            end
        end
        if (rst_n && done) begin
            chk_cnt++;
            if (busy) begin
                $display("ERROR: busy is still high in the done cycle");
                err_cnt++;
            end
            if (name_q.size() == 0) begin
                $display("ERROR: done arrived with no run pending");
                err_cnt++;
            end else begin
                name    = name_q.pop_front();
                exp_res = res_q.pop_front();
                exp_ovf = ovf_q.pop_front();
                if (result !== exp_res) begin
                    $display("FAIL %s result: expected %h actual %h", name, exp_res, result);
                    err_cnt++;
                end
                if (overflow !== exp_ovf) begin
                    $display("FAIL %s overflow: expected %b actual %b", name, exp_ovf, overflow);
                    err_cnt++;
                end
                if (cyc - start_cyc != run_latency) begin
                    $display("FAIL %s latency: expected %0d actual %0d", name, run_latency,
                             cyc - start_cyc);
                    err_cnt++;
                end
            end
        end
        // the run closes at the edge where its done is due
        if (run_open && cyc - start_cyc >= run_latency) begin
            run_open = 1'b0;
        end
        cyc = cyc + 1;
    end

endmodule

// ==== bench/tb_fwd_net.sv ====
module tb_fwd_net;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 100;
    localparam int n_w        = 1 << fwd_pkg::waddr_width;
    localparam int nn         = fwd_pkg::neuron_num;
    localparam int aw         = fwd_pkg::act_width;
    localparam int ow         = fwd_pkg::out_width;
    localparam int n_rand     = 20;
    localparam int n_runs     = n_rand + 5;
    localparam int n_loads    = n_rand + 4;
    localparam int done_limit = 20;
    // per run the latency plus a few idle edges, 20 more for the busy test
    localparam int watchdog_cycles = n_runs * 16 + 20 + n_loads * (n_w + 1) + 4 + 50;

    logic              clk;
    logic              rst_n;
    logic              start;
    fwd_pkg::act_vec_t in_vec;
    logic              w_we;
    fwd_pkg::waddr_t   w_addr;
    fwd_pkg::weight_t  w_data;
    fwd_pkg::out_vec_t result;
    logic              done;
    logic              busy;
    logic              overflow;

    int               tb_errors = 0;
    int               chk_errors;
    int               chk_checks;
    fwd_pkg::weight_t wts [n_w];

    fwd_net_top uut (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .start    (start   ),
        .in_vec   (in_vec  ),
        .w_we     (w_we    ),
        .w_addr   (w_addr  ),
        .w_data   (w_data  ),
        .result   (result  ),
        .done     (done    ),
        .busy     (busy    ),
        .overflow (overflow)
    );

    fwd_checker chk (
        .clk      (clk       ),
        .rst_n    (rst_n     ),
        .start    (start     ),
        .result   (result    ),
        .done     (done      ),
        .busy     (busy      ),
        .overflow (overflow  ),
        .errors   (chk_errors),
        .checks   (chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int waddr(input int l, input int n, input int i);
        return l * nn * nn + n * nn + i;
    endfunction

    // dense layers, floor shift, saturate, then relu capped at 255 between layers
    function automatic void fwd_model(input fwd_pkg::weight_t w [n_w],
                                      input fwd_pkg::act_vec_t x,
                                      output fwd_pkg::out_vec_t res, output logic ovf);
        longint a [nn];
        longint y [nn];
        longint acc;
        longint hi;
        longint lo;
        hi  = (longint'(1) <<< (ow - 1)) - 1;
        lo  = -(longint'(1) <<< (ow - 1));
        ovf = 1'b0;
        res = '0;
        for (int i = 0; i < nn; i++) begin
            a[i] = longint'(fwd_pkg::act_t'(x[i*aw +: aw]));
        end
        for (int l = 0; l < fwd_pkg::layer_max; l++) begin
            for (int n = 0; n < nn; n++) begin
                acc = 0;
                for (int i = 0; i < nn; i++) begin
                    acc += a[i] * longint'(w[waddr(l, n, i)]);
                end
                acc = acc >>> fwd_pkg::fraction;
                if (acc > hi) begin
                    acc = hi;
                    ovf = 1'b1;
                end else if (acc < lo) begin
                    acc = lo;
                    ovf = 1'b1;
                end
                y[n] = acc;
            end
            for (int n = 0; n < nn; n++) begin
                if (y[n] < 0) a[n] = 0;
                else if (y[n] > 255) a[n] = 255;
                else a[n] = y[n];
            end
        end
        for (int n = 0; n < nn; n++) begin
            res[n*ow +: ow] = fwd_pkg::out_t'(y[n]);
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic load_weights();
        for (int k = 0; k < n_w; k++) begin
            @(posedge clk);
            w_we   <= 1'b1;
            w_addr <= fwd_pkg::waddr_t'(k);
            w_data <= wts[k];
        end
        @(posedge clk);
        w_we <= 1'b0;
    endtask

    task automatic pulse_start(input fwd_pkg::act_vec_t vec);
        @(posedge clk);
        start  <= 1'b1;
        in_vec <= vec;
        @(posedge clk);
        start  <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        while (done !== 1'b1 && n < done_limit) begin
            @(posedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("ERROR: %s saw no done within %0d cycles", name, done_limit);
            tb_errors++;
        end
        @(posedge clk);
    endtask

    task automatic run_vector(input string name, input fwd_pkg::act_vec_t vec);
        fwd_pkg::out_vec_t exp_res;
        logic              exp_ovf;
        fwd_model(wts, vec, exp_res, exp_ovf);
        chk.expect_run(name, exp_res, exp_ovf);
        pulse_start(vec);
        wait_done(name);
    endtask

    function automatic fwd_pkg::act_vec_t rand_vec(input int lo, input int hi);
        fwd_pkg::act_vec_t v;
        for (int i = 0; i < nn; i++) begin
            v[i*aw +: aw] = aw'(int'($urandom_range(hi - lo)) + lo);
        end
        return v;
    endfunction

    task automatic set_identity();
        for (int k = 0; k < n_w; k++) begin
            wts[k] = ((k / nn) % nn == k % nn) ? 16'sd256 : 16'sd0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        fwd_pkg::act_vec_t vec;
        fwd_pkg::act_vec_t other;
        fwd_pkg::out_vec_t id_res;
        void'($urandom(32'h5e05));
        rst_n  <= 1'b0;
        start  <= 1'b0;
        in_vec <= '0;
        w_we   <= 1'b0;
        w_addr <= '0;
        w_data <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // identity weights pass non-negative inputs straight through
        set_identity();
        load_weights();
        vec    = rand_vec(0, 255);
        id_res = '0;
        for (int n = 0; n < nn; n++) begin
            id_res[n*ow +: ow] = ow'(vec[n*aw +: aw]);
        end
        chk.expect_run("identity", id_res, 1'b0);
        pulse_start(vec);
        wait_done("identity");

        for (int r = 0; r < n_rand; r++) begin
            for (int k = 0; k < n_w; k++) begin
                wts[k] = 16'(int'($urandom_range(1023)) - 512);
            end
            load_weights();
            run_vector($sformatf("random_%0d", r), rand_vec(-256, 255));
        end

        // layer 1 drives two neurons high and two low
        for (int k = 0; k < n_w; k++) begin
            wts[k] = (k < nn * nn || (k / nn) % nn < 2) ? 16'sh7fff : 16'sh8000;
        end
        load_weights();
        run_vector("saturate", {nn{9'd255}});
        set_identity();
        load_weights();
        run_vector("small_after_sat", rand_vec(0, 255));

        // neurons 0 and 1 of layer 0 go negative, layer 1 sums all inputs
        for (int k = 0; k < n_w; k++) begin
            wts[k] = (k >= nn * nn) ? 16'sd256 : 16'sd0;
        end
        for (int n = 0; n < nn; n++) begin
            wts[waddr(0, n, n)] = (n < 2) ? -16'sd256 : 16'sd256;
        end
        load_weights();
        run_vector("relu", {9'd20, 9'd30, 9'd50, 9'd100});

        // a start during the run must not restart it
        vec   = rand_vec(0, 255);
        other = rand_vec(0, 255);
        begin
            fwd_pkg::out_vec_t exp_res;
            logic              exp_ovf;
            fwd_model(wts, vec, exp_res, exp_ovf);
            chk.expect_run("start_while_busy", exp_res, exp_ovf);
        end
        pulse_start(vec);
        repeat (3) @(posedge clk);
        pulse_start(other);
        wait_done("start_while_busy");
        repeat (16) @(posedge clk);

        if (chk.pending_runs() != 0) begin
            $display("ERROR: %0d run(s) never signalled done", chk.pending_runs());
            tb_errors++;
        end
        $display("checks %0d, checker errors %0d, bench errors %0d",
                 chk_checks, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/fwd_pkg.sv
hdl/fwd_ctrl_if.sv
hdl/layer_ctrl.sv
hdl/mac_counter.sv
hdl/weight_mem.sv
hdl/neuron_array.sv
hdl/activation_stack.sv
hdl/fwd_net_top.sv
bench/fwd_checker.sv
bench/tb_fwd_net.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fwd_net
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -- "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
